// File: hdl/mul_pkg.sv
package mul_pkg;

	localparam int XLEN       = 64;
	localparam int EXT_W      = XLEN + 2;   // Two guard bits for signed/unsigned Booth
	localparam int PP_NUM     = EXT_W / 2;  // One partial product per radix-4 digit
	localparam int PROD_W     = 2 * EXT_W;
	localparam int REQ_DEPTH  = 4;
	localparam int RESP_DEPTH = 4;

	// Request as issued by the execute stage
	typedef struct packed {
		logic [1:0]      mul_signed;   // Bit 0 multiplicand, bit 1 multiplier
		logic            mulw;
		logic [XLEN-1:0] multiplicand;
		logic [XLEN-1:0] multiplier;
	} mul_req_t;

	// Full 128-bit product split in halves
	typedef struct packed {
		logic [XLEN-1:0] result_hi;
		logic [XLEN-1:0] result_lo;
	} mul_resp_t;

endpackage

// File: hdl/booth_pp_gen.sv
`timescale 1ns/1ps

module booth_pp_gen import mul_pkg::*; (
	input  logic [EXT_W-1:0]  mul_a,
	input  logic [EXT_W-1:0]  mul_b,
	output logic [PROD_W-1:0] pp [PP_NUM],
	output logic [PP_NUM-1:0] pp_neg
);

	logic [PROD_W-1:0] b_ext;
	logic [PROD_W-1:0] b_dbl;

	// mul_b is already a 66-bit two's complement value
	assign b_ext = {{EXT_W{mul_b[EXT_W-1]}}, mul_b};
	assign b_dbl = b_ext << 1;

	for (genvar i = 0; i < PP_NUM; i++) begin : g_pp
		logic [2:0]        win;
		logic [PROD_W-1:0] mag;
		logic [PROD_W-1:0] mag_sh;

		if (i == 0) begin : g_first
			assign win = {mul_a[1:0], 1'b0};  // Implicit zero below bit 0
		end else begin : g_rest
			assign win = mul_a[2*i+1:2*i-1];
		end

		always_comb begin
			case (win)
				3'b001, 3'b010: mag = b_ext;
				3'b011, 3'b100: mag = b_dbl;
				3'b101, 3'b110: mag = b_ext;
				default:        mag = '0;
			endcase
		end

		assign mag_sh = mag << (2 * i);

		// Negative digit 100/101/110, +1 goes to column 0
		assign pp_neg[i] = win[2] & ~(win[1] & win[0]);
		assign pp[i]     = pp_neg[i] ? ~mag_sh : mag_sh;
	end

endmodule

// File: hdl/wallace_column.sv
`timescale 1ns/1ps

module wallace_column import mul_pkg::*; (
	input  logic [PP_NUM-1:0] din,
	input  logic [PP_NUM-3:0] cin,
	output logic [PP_NUM-3:0] cout,
	output logic              carry,
	output logic              sum
);

	logic [10:0] s1;
	logic [21:0] l2;
	logic [6:0]  s2f;
	logic [7:0]  s2;
	logic [14:0] l3;
	logic [4:0]  s3;
	logic [9:0]  l4;
	logic [2:0]  s4f;
	logic [3:0]  s4;
	logic [6:0]  l5;
	logic [1:0]  s5f;
	logic [2:0]  s5;
	logic [4:0]  l6;
	logic        s6f;
	logic [2:0]  s6;
	logic [3:0]  l7;
	logic        s7f;
	logic [1:0]  s7;
	logic [2:0]  l8;
	logic        s8;

	// 33 -> 11, carries 0..10
	assign s1          = din[10:0] ^ din[21:11] ^ din[32:22];
	assign cout[10:0]  = (din[10:0] & din[21:11]) | (din[10:0] & din[32:22])
	                   | (din[21:11] & din[32:22]);

	// 22 -> 8, carries 11..17
	assign l2          = {cin[10:0], s1};
	assign s2f         = l2[6:0] ^ l2[13:7] ^ l2[20:14];
	assign cout[17:11] = (l2[6:0] & l2[13:7]) | (l2[6:0] & l2[20:14]) | (l2[13:7] & l2[20:14]);
	assign s2          = {l2[21], s2f};

	// 15 -> 5, carries 18..22
	assign l3          = {cin[17:11], s2};
	assign s3          = l3[4:0] ^ l3[9:5] ^ l3[14:10];
	assign cout[22:18] = (l3[4:0] & l3[9:5]) | (l3[4:0] & l3[14:10]) | (l3[9:5] & l3[14:10]);

	// 10 -> 4
	assign l4          = {cin[22:18], s3};
	assign s4f         = l4[2:0] ^ l4[5:3] ^ l4[8:6];
	assign cout[25:23] = (l4[2:0] & l4[5:3]) | (l4[2:0] & l4[8:6]) | (l4[5:3] & l4[8:6]);
	assign s4          = {l4[9], s4f};

	// 7 -> 3
	assign l5          = {cin[25:23], s4};
	assign s5f         = l5[1:0] ^ l5[3:2] ^ l5[5:4];
	assign cout[27:26] = (l5[1:0] & l5[3:2]) | (l5[1:0] & l5[5:4]) | (l5[3:2] & l5[5:4]);
	assign s5          = {l5[6], s5f};

	assign l6          = {cin[27:26], s5};
	assign s6f         = l6[0] ^ l6[1] ^ l6[2];
	assign cout[28]    = (l6[0] & l6[1]) | (l6[0] & l6[2]) | (l6[1] & l6[2]);
	assign s6          = {l6[4:3], s6f};

	assign l7          = {cin[28], s6};
	assign s7f         = l7[0] ^ l7[1] ^ l7[2];
	assign cout[29]    = (l7[0] & l7[1]) | (l7[0] & l7[2]) | (l7[1] & l7[2]);
	assign s7          = {l7[3], s7f};

	assign l8          = {cin[29], s7};
	assign s8          = ^l8;
	assign cout[30]    = (l8[0] & l8[1]) | (l8[0] & l8[2]) | (l8[1] & l8[2]);

	// Last carry group only needs a half adder
	assign sum         = s8 ^ cin[30];
	assign carry       = s8 & cin[30];

endmodule

// File: hdl/mul_core.sv
`timescale 1ns/1ps

module mul_core import mul_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      flush,
	input  logic      in_valid,
	input  mul_req_t  in_req,
	output logic      in_ready,
	output logic      out_valid,
	output mul_resp_t out_resp,
	input  logic      out_ready
);

	logic [XLEN-1:0]   op_a;
	logic [XLEN-1:0]   op_b;
	logic [EXT_W-1:0]  mul_a;
	logic [EXT_W-1:0]  mul_b;
	logic [PROD_W-1:0] pp [PP_NUM];
	logic [PP_NUM-1:0] pp_neg;
	logic [PP_NUM-1:0] col_din [PROD_W];
	logic [PP_NUM-3:0] col_cin [PROD_W];
	logic [PP_NUM-3:0] col_cout [PROD_W];
	logic [PROD_W-1:0] col_sum;
	logic [PROD_W-1:0] col_carry;
	logic              s1_valid;
	logic [PROD_W-1:0] s1_sum;
	logic [PROD_W-2:0] s1_carry;
	logic [1:0]        s1_neg;    // pp_neg[32:31], not absorbed by column 0
	logic [PROD_W-1:0] sum_full;
	logic              s2_valid;
	mul_resp_t         s2_resp;
	logic              s1_adv;
	logic              s2_adv;

	// Word mode works on sign-extended low halves
	assign op_a  = in_req.mulw ? {{32{in_req.multiplicand[31]}}, in_req.multiplicand[31:0]}
	                           : in_req.multiplicand;
	assign op_b  = in_req.mulw ? {{32{in_req.multiplier[31]}}, in_req.multiplier[31:0]}
	                           : in_req.multiplier;
	assign mul_a = {(in_req.mul_signed[0] ? {2{op_a[XLEN-1]}} : 2'b00), op_a};
	assign mul_b = {(in_req.mul_signed[1] ? {2{op_b[XLEN-1]}} : 2'b00), op_b};

	booth_pp_gen pp_gen_i (
		.mul_a  (mul_a),
		.mul_b  (mul_b),
		.pp     (pp),
		.pp_neg (pp_neg)
	);

	always_comb begin
		for (int j = 0; j < PROD_W; j++) begin
			for (int k = 0; k < PP_NUM; k++) begin
				col_din[j][k] = pp[k][j];
			end
		end
	end

	for (genvar j = 0; j < PROD_W; j++) begin : g_col
		if (j == 0) begin : g_first
			assign col_cin[j] = pp_neg[PP_NUM-3:0];
		end else begin : g_chain
			assign col_cin[j] = col_cout[j-1];
		end

		wallace_column col_i (
			.din   (col_din[j]),
			.cin   (col_cin[j]),
			.cout  (col_cout[j]),
			.carry (col_carry[j]),
			.sum   (col_sum[j])
		);
	end

	assign s2_adv   = !s2_valid || out_ready;
	assign s1_adv   = !s1_valid || s2_adv;
	assign in_ready = s1_adv;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else if (flush) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			if (s1_adv) begin
				s1_valid <= in_valid;
			end
			if (s2_adv) begin
				s2_valid <= s1_valid;
			end
		end
	end

	assign sum_full = s1_sum + {s1_carry, 1'b0}
	                + {{(PROD_W-1){1'b0}}, s1_neg[0]} + {{(PROD_W-1){1'b0}}, s1_neg[1]};

	always_ff @(posedge clk) begin
		if (s1_adv && in_valid) begin
			s1_sum   <= col_sum;
			s1_carry <= col_carry[PROD_W-2:0];
			s1_neg   <= pp_neg[PP_NUM-1:PP_NUM-2];
		end
		if (s2_adv && s1_valid) begin
			s2_resp.result_hi <= sum_full[2*XLEN-1:XLEN];
			s2_resp.result_lo <= sum_full[XLEN-1:0];
		end
	end

	assign out_valid = s2_valid;
	assign out_resp  = s2_resp;

	a_valid_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(out_valid));

	// Held result must not move under back-pressure
	a_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> $stable(out_resp));

endmodule

// File: hdl/mul_queue.sv
`timescale 1ns/1ps

module mul_queue #(
	parameter type entry_t = logic,
	parameter int  DEPTH   = 4
) (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   flush,
	input  logic   in_valid,
	input  entry_t in_data,
	output logic   in_ready,
	output logic   out_valid,
	output entry_t out_data,
	input  logic   out_ready
);

	entry_t                     mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]   wr_ptr;
	logic [$clog2(DEPTH)-1:0]   rd_ptr;
	logic [$clog2(DEPTH):0]     count;
	logic                       push;
	logic                       pop;

	assign in_ready  = (count != DEPTH);
	assign out_valid = (count != 0);
	assign out_data  = mem[rd_ptr];

	// Flush wins over any transfer in the same cycle
	assign push = in_valid && in_ready && !flush;
	assign pop  = out_valid && out_ready && !flush;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;  // Wraps, DEPTH is a power of two
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	a_count_range: assert property (@(posedge clk) disable iff (!rst_n) count <= DEPTH);

endmodule

// File: hdl/mul_unit.sv
`timescale 1ns/1ps

module mul_unit import mul_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      flush,
	input  logic      req_valid,
	input  mul_req_t  req,
	output logic      req_ready,
	output logic      resp_valid,
	output mul_resp_t resp,
	input  logic      resp_ready
);

	logic      q_valid;
	mul_req_t  q_req;
	logic      core_ready;
	logic      core_valid;
	mul_resp_t core_resp;
	logic      rq_ready;

	mul_queue #(
		.entry_t (mul_req_t),
		.DEPTH   (REQ_DEPTH)
	) req_q_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.in_valid  (req_valid),
		.in_data   (req),
		.in_ready  (req_ready),
		.out_valid (q_valid),
		.out_data  (q_req),
		.out_ready (core_ready)
	);

	mul_core core_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.in_valid  (q_valid),
		.in_req    (q_req),
		.in_ready  (core_ready),
		.out_valid (core_valid),
		.out_resp  (core_resp),
		.out_ready (rq_ready)
	);

	// Results drain to the core in request order
	mul_queue #(
		.entry_t (mul_resp_t),
		.DEPTH   (RESP_DEPTH)
	) resp_q_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.in_valid  (core_valid),
		.in_data   (core_resp),
		.in_ready  (rq_ready),
		.out_valid (resp_valid),
		.out_data  (resp),
		.out_ready (resp_ready)
	);

endmodule

// File: tests/tb_mul_unit.sv
`timescale 1ns/1ps

module tb_mul_unit import mul_pkg::*; ();

	localparam int WAIT_MAX = 200;
	localparam int RST_CYC  = 16;

	logic      clk;
	logic      rst_n;
	logic      flush;
	logic      req_valid;
	mul_req_t  req;
	logic      req_ready;
	logic      resp_valid;
	mul_resp_t resp;
	logic      resp_ready;

	string     vec_name [$];
	mul_req_t  vec_req [$];
	mul_resp_t vec_exp [$];
	int        flush_at;   // First vector after the flush marker
	int        mismatch_errs;
	int        timeout_errs;
	int        other_errs;
	bit        saw_full;
	int        cycle_cnt;

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	mul_unit dut_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.flush      (flush),
		.req_valid  (req_valid),
		.req        (req),
		.req_ready  (req_ready),
		.resp_valid (resp_valid),
		.resp       (resp),
		.resp_ready (resp_ready)
	);

	task automatic load_vectors();
		int              fd;
		int              n;
		string           line;
		string           name;
		logic [1:0]      sgn;
		logic            w;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] hi;
		logic [XLEN-1:0] lo;
		mul_req_t        r;
		mul_resp_t       e;
		flush_at = -1;
		fd = $fopen("tests/mul_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open tests/mul_golden.txt");
			other_errs++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.substr(0, 0) == "#") continue;
			n = $sscanf(line, "%s %b %b %h %h %h %h", name, sgn, w, a, b, hi, lo);
			if (n != 7) begin
				$display("Malformed golden line: %s", line);
				other_errs++;
			end else if (name == "flush") begin
				flush_at = vec_name.size();
			end else begin
				r.mul_signed   = sgn;
				r.mulw         = w;
				r.multiplicand = a;
				r.multiplier   = b;
				e.result_hi    = hi;
				e.result_lo    = lo;
				vec_name.push_back(name);
				vec_req.push_back(r);
				vec_exp.push_back(e);
			end
		end
		$fclose(fd);
		if (flush_at < 1 || flush_at >= vec_name.size()) begin
			$display("Golden file has no usable flush marker");
			other_errs++;
		end
	endtask

	// Called on a falling edge and returns one falling edge after the transfer
	task automatic send_req(input mul_req_t r);
		int waited;
		waited    = 0;
		req_valid = 1'b1;
		req       = r;
		while (!req_ready && waited < WAIT_MAX) begin
			saw_full = 1'b1;
			@(negedge clk);
			waited++;
		end
		if (!req_ready) begin
			$display("Timeout: req_ready stayed low for a pending request");
			timeout_errs++;
		end
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic drive_block(input int first, input int last, input bit gaps);
		int gap;
		for (int i = first; i < last; i++) begin
			if (gaps) begin
				gap = $urandom_range(3, 0);
				repeat (gap) @(negedge clk);
			end
			send_req(vec_req[i]);
		end
	endtask

	task automatic compare_resp(input int idx);
		mul_resp_t e;
		e = vec_exp[idx];
		if (resp.result_hi !== e.result_hi) begin
			$display("FAIL %s hi expected %h actual %h", vec_name[idx], e.result_hi,
				resp.result_hi);
			mismatch_errs++;
		end
		if (resp.result_lo !== e.result_lo) begin
			$display("FAIL %s lo expected %h actual %h", vec_name[idx], e.result_lo,
				resp.result_lo);
			mismatch_errs++;
		end
	endtask

	// Scoreboard with hold_low cycles of full stall before the chosen pattern
	task automatic check_block(input int first, input int last, input int hold_low,
		input bit rnd);
		int idx;
		int idle;
		int cyc;
		idx  = first;
		idle = 0;
		cyc  = 0;
		while (idx < last && idle < WAIT_MAX) begin
			if (cyc < hold_low) begin
				resp_ready = 1'b0;
			end else if (rnd) begin
				resp_ready = ($urandom_range(1, 0) == 1);
			end else begin
				resp_ready = 1'b1;
			end
			if (resp_valid && resp_ready) begin
				compare_resp(idx);
				idx++;
				idle = 0;
			end else begin
				idle++;
			end
			cyc++;
			@(negedge clk);
		end
		if (idx < last) begin
			$display("Timeout: resp_valid never came for vector %0d", idx);
			timeout_errs++;
		end
		resp_ready = 1'b1;
	endtask

	task automatic run_block(input int first, input int last, input bit gaps,
		input int hold_low, input bit rnd);
		fork
			drive_block(first, last, gaps);
			check_block(first, last, hold_low, rnd);
		join
	endtask

	task automatic expect_idle(input int cycles, input string what);
		for (int i = 0; i < cycles; i++) begin
			if (resp_valid) begin
				$display("Unexpected response %s", what);
				other_errs++;
			end
			@(negedge clk);
		end
	endtask

	task automatic flush_test();
		resp_ready = 1'b0;
		for (int i = 0; i < 6; i++) send_req(vec_req[i]);
		repeat (3) @(negedge clk);
		if (!resp_valid) begin
			$display("No response was pending when the flush was issued");
			other_errs++;
		end
		req_valid = 1'b1;  // Offered in the flush cycle and must be dropped
		req       = vec_req[0];
		flush     = 1'b1;
		@(negedge clk);
		flush      = 1'b0;
		req_valid  = 1'b0;
		resp_ready = 1'b1;
		expect_idle(20, "after flush");
		if (!req_ready) begin
			$display("req_ready is low after flush");
			other_errs++;
		end
	endtask

	initial begin
		int start;
		void'($urandom(32'hca08_6efb));
		mismatch_errs = 0;
		timeout_errs  = 0;
		other_errs    = 0;
		saw_full      = 1'b0;
		rst_n         = 1'b0;
		flush         = 1'b0;
		req_valid     = 1'b0;
		req           = '0;
		resp_ready    = 1'b0;
		load_vectors();
		repeat (RST_CYC) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		if (!req_ready || resp_valid) begin
			$display("Wrong handshake state after reset");
			other_errs++;
		end
		if (other_errs == 0) begin
			start = cycle_cnt;
			run_block(0, flush_at, 1'b0, 0, 1'b0);
			if (cycle_cnt - start > flush_at + 12) begin
				$display("Back-to-back requests did not overlap in the pipeline");
				other_errs++;
			end
			expect_idle(10, "after back-to-back block");

			saw_full = 1'b0;
			run_block(0, flush_at, 1'b1, 60, 1'b1);
			if (!saw_full) begin
				$display("req_ready never fell while the outputs were stalled");
				other_errs++;
			end
			expect_idle(10, "after back-pressure block");

			flush_test();
			run_block(flush_at, vec_name.size(), 1'b1, 0, 1'b1);
			expect_idle(10, "after last block");
		end
		$display("Errors: %0d mismatches, %0d timeouts, %0d other", mismatch_errs,
			timeout_errs, other_errs);
		if (mismatch_errs + timeout_errs + other_errs == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: vlog.f
hdl/mul_pkg.sv
hdl/booth_pp_gen.sv
hdl/wallace_column.sv
hdl/mul_core.sv
hdl/mul_queue.sv
hdl/mul_unit.sv
tests/tb_mul_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -sv \
	-f vlog.f --top-module tb_mul_unit -o sim_tb_mul_unit \
	|| { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/sim_tb_mul_unit)
echo "$sim_out"

echo "$sim_out" | grep -qx "Test OK" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: tests/mul_golden.txt
# name mul_signed(bit1 multiplier, bit0 multiplicand) mulw multiplicand multiplier hi lo
# Operands and halves in hex, a line named flush marks the flush point
mulhu_zero       00 0 ffffffffffffffff 0000000000000000 0000000000000000 0000000000000000
mulhu_one        00 0 ffffffffffffffff 0000000000000001 0000000000000000 ffffffffffffffff
mulhu_allones    00 0 ffffffffffffffff ffffffffffffffff fffffffffffffffe 0000000000000001
mulhu_min_min    00 0 8000000000000000 8000000000000000 4000000000000000 0000000000000000
mulhu_max_two    00 0 7fffffffffffffff 0000000000000002 0000000000000000 fffffffffffffffe
mul_small        11 0 0000000000000003 0000000000000005 0000000000000000 000000000000000f
mul_neg_one      11 0 ffffffffffffffff 0000000000000001 ffffffffffffffff ffffffffffffffff
mulh_neg_neg     11 0 ffffffffffffffff ffffffffffffffff 0000000000000000 0000000000000001
mulh_min_min     11 0 8000000000000000 8000000000000000 4000000000000000 0000000000000000
mulh_min_neg1    11 0 8000000000000000 ffffffffffffffff 0000000000000000 8000000000000000
mulh_min_one     11 0 8000000000000000 0000000000000001 ffffffffffffffff 8000000000000000
mulh_max_max     11 0 7fffffffffffffff 7fffffffffffffff 3fffffffffffffff 0000000000000001
mulh_max_min     11 0 7fffffffffffffff 8000000000000000 c000000000000000 8000000000000000
mul_mixed_sign   11 0 fffffffffffffffd 0000000000000007 ffffffffffffffff ffffffffffffffeb
mul_neg_pos_big  11 0 fffffffffffffffe 4000000000000000 ffffffffffffffff 8000000000000000
mul_pow32        11 0 0000000100000000 0000000100000000 0000000000000001 0000000000000000
mulhu_pattern    00 0 0000000100000001 0000000100000001 0000000000000001 0000000200000001
mulh_neg_pattern 11 0 fffffffeffffffff 0000000100000001 fffffffffffffffe fffffffdffffffff
mulhu_a5         00 0 aaaaaaaaaaaaaaaa 0000000000000003 0000000000000001 fffffffffffffffe
mulh_a5          11 0 aaaaaaaaaaaaaaaa 0000000000000003 fffffffffffffffe fffffffffffffffe
mulhsu_neg_a     01 0 ffffffffffffffff ffffffffffffffff ffffffffffffffff 0000000000000001
mulhsu_neg_b     10 0 ffffffffffffffff ffffffffffffffff ffffffffffffffff 0000000000000001
mulhsu_a_only    01 0 0000000000000001 ffffffffffffffff 0000000000000000 ffffffffffffffff
mulhsu_b_only    10 0 0000000000000001 ffffffffffffffff ffffffffffffffff ffffffffffffffff
mulhsu_min_s     01 0 8000000000000000 0000000000000002 ffffffffffffffff 0000000000000000
mulhsu_min_u     10 0 8000000000000000 0000000000000002 0000000000000001 0000000000000000
mulhsu_minmin    01 0 8000000000000000 8000000000000000 c000000000000000 0000000000000000
mulhsu_neg3      10 0 0000000000000005 fffffffffffffffd ffffffffffffffff fffffffffffffff1
mulw_basic       11 1 deadbeef00000003 1234567800000005 0000000000000000 000000000000000f
mulw_neg         11 1 12345678ffffffff abcdef0000000007 ffffffffffffffff fffffffffffffff9
mulw_min         11 1 0123456780000000 fedcba9880000000 0000000000000000 4000000000000000
mulw_overflow    11 1 ffffffff7fffffff 0000000100000002 0000000000000000 00000000fffffffe
mulw_unsigned    00 1 0000000080000000 5555555500000001 0000000000000000 ffffffff80000000
mulw_neg_neg     11 1 77777777fffffffe 88888888fffffffd 0000000000000000 0000000000000006
flush            00 0 0000000000000000 0000000000000000 0000000000000000 0000000000000000
post_zero        11 0 0000000000000000 8000000000000000 0000000000000000 0000000000000000
post_square      00 0 00000000ffffffff 00000000ffffffff 0000000000000000 fffffffe00000001
post_signed_sq   11 0 ffffffff00000001 ffffffff00000001 0000000000000000 fffffffe00000001
post_mulhsu      01 0 ffffffff00000001 00000000ffffffff ffffffffffffffff 00000001ffffffff
post_mulw        11 1 aaaaaaaa00000010 5555555500000010 0000000000000000 0000000000000100
post_mulhu_max   00 0 ffffffffffffffff 8000000000000000 7fffffffffffffff 8000000000000000
post_mulh_neg    11 0 ffffffffffffffff 8000000000000000 0000000000000000 8000000000000000
post_mixed       10 0 ffffffffffffffff 8000000000000000 8000000000000000 8000000000000000
post_pow         11 0 0000000000010000 0000010000000000 0000000000000000 0100000000000000
post_pow_hi      00 0 0001000000000000 0000100000000000 0000000010000000 0000000000000000
post_ff          00 0 00000000000000ff 00000000000000ff 0000000000000000 000000000000fe01
post_neg_ff      11 0 ffffffffffffff01 00000000000000ff ffffffffffffffff ffffffffffff01ff
